// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = datapathTb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: hw/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module aluUnit (
	input  wire logic                      Clock,
	input  wire logic                      arstN,
	input  wire datapath_pkg::aluOpT       aluOp,
	input  wire logic [`DP_DATA_WIDTH-1:0] y,     // operand A
	input  wire logic [`DP_DATA_WIDTH-1:0] busIn, // operand B
	input  wire logic                      zLoad,
	output logic      [`DP_DATA_WIDTH-1:0] zHigh,
	output logic      [`DP_DATA_WIDTH-1:0] zLow
);

	import datapath_pkg::*;

	localparam int W = `DP_DATA_WIDTH;

	logic [`DP_SHAMT_WIDTH-1:0] shamt;
	logic [2*W-1:0]             yTwice;    // A next to itself, for rotates
	logic [2*W-1:0]             rorWide;
	logic [2*W-1:0]             rolWide;
	logic signed [2*W-1:0]      product;
	logic [W-1:0]               result;    // 32-bit result of the simple ops
	logic [2*W-1:0]             resultWide;
	logic [2*W-1:0]             z;

	assign shamt  = busIn[`DP_SHAMT_WIDTH-1:0];
	assign yTwice = {y, y};

	// rotate by shifting the doubled word, the wanted half falls out
	assign rorWide = yTwice >> shamt;
	assign rolWide = yTwice << shamt;

	assign product = $signed(y) * $signed(busIn);

	always_comb begin
		result = '0;
		case (aluOp)
			Add:     result = y + busIn;
			Sub:     result = y - busIn;
			And:     result = y & busIn;
			Or:      result = y | busIn;
			Shr:     result = y >> shamt;
			Shra:    result = $signed(y) >>> shamt; // sign bit fills from the left
			Shl:     result = y << shamt;
			Ror:     result = rorWide[W-1:0];
			Rol:     result = rolWide[2*W-1:W];
			Neg:     result = -busIn;               // two's complement of B
			Not:     result = ~busIn;
			default: result = '0;                   // Mul goes through the wide path
		endcase
	end

	// only Mul fills the upper half, everything else leaves ZHigh at zero
	always_comb begin
		if (aluOp == Mul)
			resultWide = product;
		else
			resultWide = {{W{1'b0}}, result};
	end

	// Z register
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			z <= '0;
		end else if (zLoad) begin
			z <= resultWide;
		end
	end

	assign zHigh = z[2*W-1:W];
	assign zLow  = z[W-1:0];

endmodule

`default_nettype wire

// File: hw/busMux.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module busMux (
	input  wire datapath_pkg::busSourceT   busSource,
	input  wire logic [`DP_DATA_WIDTH-1:0] regValues [`DP_NUM_REGS],
	input  wire logic [`DP_DATA_WIDTH-1:0] hi,
	input  wire logic [`DP_DATA_WIDTH-1:0] lo,
	input  wire logic [`DP_DATA_WIDTH-1:0] zHigh,
	input  wire logic [`DP_DATA_WIDTH-1:0] zLow,
	input  wire logic [`DP_DATA_WIDTH-1:0] pc,
	input  wire logic [`DP_DATA_WIDTH-1:0] mdr,
	input  wire logic [`DP_DATA_WIDTH-1:0] inPort,
	output logic      [`DP_DATA_WIDTH-1:0] busOut
);

	import datapath_pkg::*;

	localparam int RegIdxWidth = $clog2(`DP_NUM_REGS);

	logic [RegIdxWidth-1:0] regIdx;

	// general register codes start at zero, low bits pick the register
	assign regIdx = busSource[RegIdxWidth-1:0];

	always_comb begin
		busOut = '0;
		case (busSource)
			HI:      busOut = hi;
			LO:      busOut = lo;
			ZHigh:   busOut = zHigh;
			ZLow:    busOut = zLow;
			PC:      busOut = pc;
			MDR:     busOut = mdr;
			InPort:  busOut = inPort;
			None:    busOut = '0;
			default: begin
				// R0..R15, any unused code falls through to zero
				if (busSource <= R15)
					busOut = regValues[regIdx];
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module datapath (
	input  wire logic                      Clock,
	input  wire logic                      arstN,
	// control step inputs
	input  wire datapath_pkg::busSourceT   busSource,
	input  wire logic [`DP_NUM_REGS-1:0]   regLoad,
	input  wire logic                      hiLoad,
	input  wire logic                      loLoad,
	input  wire logic                      pcLoad,
	input  wire logic                      incPc,
	input  wire logic                      marLoad,
	input  wire logic                      irLoad,
	input  wire logic                      yLoad,
	input  wire logic                      mdrLoad,
	input  wire logic                      memRead,
	input  wire logic                      zLoad,
	input  wire datapath_pkg::aluOpT       aluOp,
	// data in
	input  wire logic [`DP_DATA_WIDTH-1:0] mDataIn,
	input  wire logic [`DP_DATA_WIDTH-1:0] inPort,
	// data out
	output logic      [`DP_DATA_WIDTH-1:0] busOut,
	output logic      [`DP_DATA_WIDTH-1:0] marOut,
	output logic      [`DP_DATA_WIDTH-1:0] irOut
);

	logic [`DP_DATA_WIDTH-1:0] regValues [`DP_NUM_REGS];
	logic [`DP_DATA_WIDTH-1:0] hi;
	logic [`DP_DATA_WIDTH-1:0] lo;
	logic [`DP_DATA_WIDTH-1:0] pc;
	logic [`DP_DATA_WIDTH-1:0] y;
	logic [`DP_DATA_WIDTH-1:0] mdr;
	logic [`DP_DATA_WIDTH-1:0] zHigh;
	logic [`DP_DATA_WIDTH-1:0] zLow;

	registerBank uRegisterBank (
		.Clock     (Clock),
		.arstN     (arstN),
		.busIn     (busOut),
		.regLoad   (regLoad),
		.hiLoad    (hiLoad),
		.loLoad    (loLoad),
		.regValues (regValues),
		.hi        (hi),
		.lo        (lo)
	);

	specialRegisters uSpecialRegisters (
		.Clock   (Clock),
		.arstN   (arstN),
		.busIn   (busOut),
		.mDataIn (mDataIn),
		.pcLoad  (pcLoad),
		.incPc   (incPc),
		.marLoad (marLoad),
		.irLoad  (irLoad),
		.yLoad   (yLoad),
		.mdrLoad (mdrLoad),
		.memRead (memRead),
		.pc      (pc),
		.mar     (marOut), // MAR and IR go straight out
		.ir      (irOut),
		.y       (y),
		.mdr     (mdr)
	);

	// single driver of the shared bus
	busMux uBusMux (
		.busSource (busSource),
		.regValues (regValues),
		.hi        (hi),
		.lo        (lo),
		.zHigh     (zHigh),
		.zLow      (zLow),
		.pc        (pc),
		.mdr       (mdr),
		.inPort    (inPort),
		.busOut    (busOut)
	);

	aluUnit uAluUnit (
		.Clock (Clock),
		.arstN (arstN),
		.aluOp (aluOp),
		.y     (y),
		.busIn (busOut),
		.zLoad (zLoad),
		.zHigh (zHigh),
		.zLow  (zLow)
	);

endmodule

`default_nettype wire

// File: hw/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

	// bus drivers, R0..R15 sit at codes 0..15 so the mux can index with them
	typedef enum logic [4:0] {
		R0, R1, R2, R3, R4, R5, R6, R7,
		R8, R9, R10, R11, R12, R13, R14, R15,
		HI,
		LO,
		ZHigh,
		ZLow,
		PC,
		MDR,
		InPort,
		None // nothing selected, bus reads zero
	} busSourceT;

	typedef enum logic [3:0] {
		Add,
		Sub,
		And,
		Or,
		Shr,  // logical right
		Shra, // arithmetic right
		Shl,
		Ror,
		Rol,
		Neg,
		Not,
		Mul   // signed, full 64-bit product
	} aluOpT;

endpackage

`default_nettype wire

// File: hw/registerBank.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module registerBank (
	input  wire logic                      Clock,
	input  wire logic                      arstN,
	input  wire logic [`DP_DATA_WIDTH-1:0] busIn,
	input  wire logic [`DP_NUM_REGS-1:0]   regLoad, // one bit per general register
	input  wire logic                      hiLoad,
	input  wire logic                      loLoad,
	output logic      [`DP_DATA_WIDTH-1:0] regValues [`DP_NUM_REGS],
	output logic      [`DP_DATA_WIDTH-1:0] hi,
	output logic      [`DP_DATA_WIDTH-1:0] lo
);

	// general registers, each captures the bus on its own load bit
	genvar i;
	generate
		for (i = 0; i < `DP_NUM_REGS; i++) begin : genReg
			always_ff @(posedge Clock or negedge arstN) begin
				if (!arstN) begin
					regValues[i] <= '0;
				end else if (regLoad[i]) begin
					regValues[i] <= busIn;
				end
			end
		end
	endgenerate

	// HI and LO normally receive the two halves of Z after a multiply
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			hi <= '0;
		end else if (hiLoad) begin
			hi <= busIn;
		end
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			lo <= '0;
		end else if (loLoad) begin
			lo <= busIn;
		end
	end

endmodule

`default_nettype wire

// File: hw/specialRegisters.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module specialRegisters (
	input  wire logic                      Clock,
	input  wire logic                      arstN,
	input  wire logic [`DP_DATA_WIDTH-1:0] busIn,
	input  wire logic [`DP_DATA_WIDTH-1:0] mDataIn, // read data from memory
	input  wire logic                      pcLoad,
	input  wire logic                      incPc,
	input  wire logic                      marLoad,
	input  wire logic                      irLoad,
	input  wire logic                      yLoad,
	input  wire logic                      mdrLoad,
	input  wire logic                      memRead,
	output logic      [`DP_DATA_WIDTH-1:0] pc,
	output logic      [`DP_DATA_WIDTH-1:0] mar,
	output logic      [`DP_DATA_WIDTH-1:0] ir,
	output logic      [`DP_DATA_WIDTH-1:0] y,
	output logic      [`DP_DATA_WIDTH-1:0] mdr
);

	logic [`DP_DATA_WIDTH-1:0] mdrIn;

	// MDR input mux, memory side wins while a read is in progress
	assign mdrIn = memRead ? mDataIn : busIn;

	// program counter
	// increment and load in the same cycle means increment, so that
	// PC out / MAR in / incPc can share one step of the fetch
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (incPc) begin
			pc <= pc + 1'b1;
		end else if (pcLoad) begin
			pc <= busIn;
		end
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			mar <= '0;
			ir  <= '0;
		end else begin
			if (marLoad)
				mar <= busIn; // address toward memory
			if (irLoad)
				ir <= busIn;  // instruction word, decoded outside
		end
	end

	// Y holds operand A for the ALU
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			y <= '0;
		end else if (yLoad) begin
			y <= busIn;
		end
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			mdr <= '0;
		end else if (mdrLoad) begin
			mdr <= mdrIn;
		end
	end

endmodule

`default_nettype wire

// File: include/datapath_defines.svh
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// width of the shared bus and of every register in the datapath
`define DP_DATA_WIDTH 32

// general purpose registers R0 to R15
`define DP_NUM_REGS 16

// low bus bits taken as the shift or rotate count
`define DP_SHAMT_WIDTH 5

`endif

// File: sim/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module datapathTb;

	import datapath_pkg::*;

	localparam int ResetTimeout = 20;               // cycles
	localparam int NumLoadable  = `DP_NUM_REGS + 2; // R0..R15, HI, LO

	logic Clock;
	logic arstN;
	busSourceT                 busSource;
	logic [`DP_NUM_REGS-1:0]   regLoad;
	logic                      hiLoad;
	logic                      loLoad;
	logic                      pcLoad;
	logic                      incPc;
	logic                      marLoad;
	logic                      irLoad;
	logic                      yLoad;
	logic                      mdrLoad;
	logic                      memRead;
	logic                      zLoad;
	aluOpT                     aluOp;
	logic [`DP_DATA_WIDTH-1:0] mDataIn;
	logic [`DP_DATA_WIDTH-1:0] inPort;
	logic [`DP_DATA_WIDTH-1:0] busOut;
	logic [`DP_DATA_WIDTH-1:0] marOut;
	logic [`DP_DATA_WIDTH-1:0] irOut;
	logic [31:0]               seed;
	int                        errorCount;
	int                        checkCount;

	tbClock uClock (.Clock(Clock), .arstN(arstN));

	datapath DUT (.*);

	function automatic logic [31:0] nextRandom();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	// reference ALU, A is Y and B is the bus
	function automatic logic [63:0] modelAlu(input aluOpT op, input logic [31:0] a,
		input logic [31:0] b);
		int          n;
		logic [31:0] r;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		n  = int'(b[4:0]); // only the low five bits count
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		case (op)
			Add:     r = a + b;
			Sub:     r = a - b;
			And:     r = a & b;
			Or:      r = a | b;
			Shr:     r = a >> n;
			Shra:    r = (a >> n) | (a[31] ? ~(32'hffffffff >> n) : 32'h0);
			Shl:     r = a << n;
			Ror:     r = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
			Rol:     r = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
			Neg:     r = ~b + 32'd1;
			Not:     r = ~b;
			default: r = 32'h0;
		endcase
		if (op == Mul)
			return sa * sb;
		return {32'h0, r};
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic reportTest(input string name, input int errorsAtStart, input int checksAtStart);
		$display("%s: %0d checks, %0d mismatches", name, checkCount - checksAtStart,
			errorCount - errorsAtStart);
	endtask

	task automatic clearControls();
		busSource = None;
		regLoad   = '0;
		{hiLoad, loLoad, pcLoad, incPc, marLoad} = '0;
		{irLoad, yLoad, mdrLoad, memRead, zLoad} = '0;
		aluOp     = Add;
	endtask

	task automatic waitForReset(output logic released);
		int cycles;
		released = 1'b0;
		cycles   = 0;
		while (!released && cycles < ResetTimeout) begin
			@(posedge Clock);
			released = arstN;
			cycles++;
		end
	endtask

	task automatic setLoad(input busSourceT dst);
		if (dst <= R15)
			regLoad[dst[3:0]] = 1'b1;
		else if (dst == HI)
			hiLoad = 1'b1;
		else if (dst == LO)
			loLoad = 1'b1;
		else if (dst == PC)
			pcLoad = 1'b1;
	endtask

	// memory word into MDR, then MDR over the bus into the target
	task automatic loadReg(input busSourceT dst, input logic [31:0] value);
		@(negedge Clock);
		clearControls();
		mDataIn = value;
		memRead = 1'b1;
		mdrLoad = 1'b1;
		@(negedge Clock);
		clearControls();
		busSource = MDR;
		setLoad(dst);
	endtask

	task automatic moveReg(input busSourceT src, input busSourceT dst);
		@(negedge Clock);
		clearControls();
		busSource = src;
		setLoad(dst);
	endtask

	task automatic aluOp2(input busSourceT aSrc, input busSourceT bSrc, input aluOpT op,
		input busSourceT dst);
		@(negedge Clock);
		clearControls();
		busSource = aSrc;
		yLoad     = 1'b1;
		@(negedge Clock);
		clearControls();
		busSource = bSrc;
		aluOp     = op;
		zLoad     = 1'b1;
		moveReg(ZLow, dst);
	endtask

	// no loads in this cycle, so the bus is settled at the rising edge
	task automatic readBus(input busSourceT src, output logic [31:0] value);
		@(negedge Clock);
		clearControls();
		busSource = src;
		@(posedge Clock);
		value = busOut;
	endtask

	task automatic runAluCase(input string name, input aluOpT op, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] expected;
		logic [31:0] got;
		expected = modelAlu(op, a, b);
		loadReg(R1, a);
		loadReg(R2, b);
		aluOp2(R1, R2, op, R3);
		readBus(R3, got);
		compareValue(name, expected[31:0], got);
		readBus(ZHigh, got);
		compareValue({name, " zhigh"}, expected[63:32], got);
	endtask

	task automatic testRegisters();
		int          errorsAtStart;
		int          checksAtStart;
		logic [31:0] values [NumLoadable];
		logic [31:0] got;
		busSourceT   src;
		errorsAtStart = errorCount;
		checksAtStart = checkCount;
		for (int i = 0; i <= int'(MDR); i++) begin // everything is zero out of reset
			src = busSourceT'(i);
			readBus(src, got);
			compareValue({"reset ", src.name()}, 32'h0, got);
		end
		for (int i = 0; i < NumLoadable; i++) begin
			values[i] = nextRandom();
			loadReg(busSourceT'(i), values[i]);
		end
		// read back after all loads so a stray write shows up
		for (int i = 0; i < NumLoadable; i++) begin
			src = busSourceT'(i);
			readBus(src, got);
			compareValue({"load ", src.name()}, values[i], got);
		end
		@(negedge Clock);
		inPort = nextRandom();
		readBus(InPort, got);
		compareValue("inport", inPort, got);
		reportTest("registers", errorsAtStart, checksAtStart);
	endtask

	task automatic testShra();
		int          errorsAtStart;
		int          checksAtStart;
		logic [31:0] a;
		errorsAtStart = errorCount;
		checksAtStart = checkCount;
		for (int amt = 0; amt < 32; amt++) begin
			a     = nextRandom();
			a[31] = amt[0]; // odd amounts get a negative operand
			runAluCase("shra", Shra, a, 32'(amt));
		end
		reportTest("shra", errorsAtStart, checksAtStart);
	endtask

	task automatic testOpList(input string name, input aluOpT ops [6], input int numOps);
		int          errorsAtStart;
		int          checksAtStart;
		logic [31:0] a;
		logic [31:0] b;
		aluOpT       op;
		errorsAtStart = errorCount;
		checksAtStart = checkCount;
		for (int k = 0; k < numOps; k++) begin
			op = ops[k];
			for (int i = 0; i < 6; i++) begin
				a = nextRandom();
				b = nextRandom(); // upper bits of a shift amount are noise
				runAluCase(op.name(), op, a, b);
			end
		end
		reportTest(name, errorsAtStart, checksAtStart);
	endtask

	task automatic testMul();
		int          errorsAtStart;
		int          checksAtStart;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] got;
		logic [63:0] expected;
		errorsAtStart = errorCount;
		checksAtStart = checkCount;
		for (int i = 0; i < 8; i++) begin
			a = nextRandom();
			b = nextRandom();
			if (i == 0) begin
				a = 32'h80000000;
				b = 32'h80000000;
			end
			expected = modelAlu(Mul, a, b);
			loadReg(R7, a);
			loadReg(R8, b);
			aluOp2(R7, R8, Mul, LO);
			moveReg(ZHigh, HI);
			readBus(HI, got);
			compareValue("mul hi", expected[63:32], got);
			readBus(LO, got);
			compareValue("mul lo", expected[31:0], got);
		end
		reportTest("mul", errorsAtStart, checksAtStart);
	endtask

	task automatic testFetch();
		int          errorsAtStart;
		int          checksAtStart;
		logic [31:0] pcValue;
		logic [31:0] word;
		logic [31:0] got;
		errorsAtStart = errorCount;
		checksAtStart = checkCount;
		pcValue = nextRandom();
		word    = nextRandom();
		loadReg(PC, pcValue);
		@(negedge Clock);
		clearControls();
		busSource = PC; // PC out, MAR in, increment in one step
		marLoad   = 1'b1;
		incPc     = 1'b1;
		readBus(PC, got);
		compareValue("fetch pc", pcValue + 32'd1, got);
		compareValue("fetch mar", pcValue, marOut);
		@(negedge Clock);
		clearControls();
		mDataIn = word;
		memRead = 1'b1;
		mdrLoad = 1'b1;
		@(negedge Clock);
		clearControls();
		busSource = MDR;
		irLoad    = 1'b1;
		readBus(MDR, got);
		compareValue("fetch ir", word, irOut);
		reportTest("fetch", errorsAtStart, checksAtStart);
	endtask

	initial begin
		logic released;
		seed       = 32'hd416fed5;
		errorCount = 0;
		checkCount = 0;
		clearControls();
		mDataIn = '0;
		inPort  = '0;
		waitForReset(released);
		if (!released) begin
			errorCount++;
			$display("reset still asserted after %0d cycles, no test was run", ResetTimeout);
		end else begin
			testRegisters();
			testShra();
			testOpList("shifts and rotates", '{Shl, Shr, Ror, Rol, Add, Add}, 4);
			testOpList("arith and logic", '{Add, Sub, And, Or, Neg, Not}, 6);
			testMul();
			testFetch();
		end
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/datapath_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module datapath_sva (
	input wire logic                      Clock,
	input wire logic                      arstN,
	input wire logic [`DP_NUM_REGS-1:0]   regLoad,
	input wire logic                      memRead,
	input wire logic                      mdrLoad,
	input wire logic                      zLoad,
	input wire datapath_pkg::aluOpT       aluOp,
	input wire logic [`DP_DATA_WIDTH-1:0] zHigh
);

	import datapath_pkg::*;

	// at most one general register takes the bus per cycle
	regLoadOneHot: assert property (@(posedge Clock) disable iff (!arstN)
		$onehot0(regLoad))
		else $error("several general registers loaded from the bus at once");

	memReadNeedsMdr: assert property (@(posedge Clock) disable iff (!arstN)
		memRead |-> mdrLoad)
		else $error("memRead high without mdrLoad");

	// only a multiply may leave anything in the upper half of Z
	zHighClear: assert property (@(posedge Clock) disable iff (!arstN)
		(zLoad && aluOp != Mul) |=> (zHigh == '0))
		else $error("ZHigh not zero after a 32-bit ALU result");

endmodule

bind datapath datapath_sva uDatapathSva (
	.Clock   (Clock),
	.arstN   (arstN),
	.regLoad (regLoad),
	.memRead (memRead),
	.mdrLoad (mdrLoad),
	.zLoad   (zLoad),
	.aluOp   (aluOp),
	.zHigh   (zHigh)
);

`default_nettype wire

// File: sim/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int PeriodNs    = 100,
	parameter int ResetCycles = 4
) (
	output logic Clock,
	output logic arstN
);

	initial begin
		Clock = 1'b0;
		forever #(PeriodNs / 2) Clock = ~Clock;
	end

	// reset released on a falling edge, away from the capture edge
	initial begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge Clock);
		@(negedge Clock);
		arstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hw/datapath_pkg.sv
hw/registerBank.sv
hw/specialRegisters.sv
hw/busMux.sv
hw/aluUnit.sv
hw/datapath.sv
sim/datapath_sva.sv
sim/tbClock.sv
sim/datapathTb.sv
